// ==== Makefile ====
# Verilator build and run of the flash controller testbench

VERILATOR ?= verilator
TOP       ?= tb_flash_ctrl
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "test failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "test did not complete"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
verilog/flash_pkg.sv
verilog/spi_clk_gen.sv
verilog/spi_tran_engine.sv
verilog/flash_op_seq.sv
verilog/flash_ctrl_top.sv
test/flash_model.sv
test/tb_flash_ctrl.sv

// ==== test/flash_model.sv ====
`default_nettype none
`timescale 1ns/100ps

module flash_model (
    input  wire  spi_clk_i,
    input  wire  spi_ss_i,
    input  wire  spi_mosi_i,
    output logic spi_miso_o
);

    import flash_pkg::*;

    localparam int          MEM_BYTES = 8192;      // two 4 KB subsectors
    localparam logic [23:0] PROT_BASE = 24'h001F00;

    logic [7:0]  mem [0:MEM_BYTES-1];
    logic        wel;
    logic        prog_err;
    logic        erase_err;
    int          busy_polls;
    logic [31:0] rng;
    logic [7:0]  cmd;
    logic [7:0]  in_byte;
    logic [7:0]  out_sh;
    logic [23:0] addr;
    logic [7:0]  pbuf [0:3];
    int          pcount;
    int          bit_cnt;
    int          byte_idx;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'hFF;
        end
        wel        = 1'b0;
        prog_err   = 1'b0;
        erase_err  = 1'b0;
        busy_polls = 0;
        rng        = 32'd89166;
        cmd        = 8'h00;
        out_sh     = 8'h00;
        spi_miso_o = 1'b0;
        byte_idx   = 0;
        bit_cnt    = 0;
    end

    // flag status byte, each read counts as one poll
    task automatic load_status();
        out_sh = 8'h00;
        out_sh[FSR_READY_BIT]     = (busy_polls == 0);
        out_sh[FSR_PROG_ERR_BIT]  = prog_err;
        out_sh[FSR_ERASE_ERR_BIT] = erase_err;
        if (busy_polls > 0) busy_polls--;
    endtask

    task automatic byte_done(input logic [7:0] b);
        int k;
        if (byte_idx == 0) begin
            cmd = b;
            if (b == CMD_READ_FLAG_STATUS) load_status();
        end else if (byte_idx <= 3) begin
            addr = {addr[15:0], b};
            if (byte_idx == 3 && cmd == CMD_READ) out_sh = mem[addr[12:0]];
        end else begin
            k = byte_idx - 4;
            if (cmd == CMD_READ) begin
                out_sh = mem[addr[12:0] + 13'(k + 1)];   // next byte ready for next fall
            end else if (cmd == CMD_PAGE_PROG && k < 4) begin
                pbuf[k] = b;
                pcount  = k + 1;
            end
        end
    endtask

    always @(negedge spi_ss_i) begin
        bit_cnt  = 0;
        byte_idx = 0;
        pcount   = 0;
        in_byte  = 8'h00;
    end

    always @(posedge spi_clk_i) begin
        if (!spi_ss_i) begin
            in_byte = {in_byte[6:0], spi_mosi_i};
            bit_cnt++;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                byte_done(in_byte);
                byte_idx++;
            end
        end
    end

    always @(negedge spi_clk_i) begin
        if (!spi_ss_i) begin
            spi_miso_o = out_sh[7];
            out_sh     = out_sh << 1;
        end
    end

    // commands take effect when chip select rises
    always @(posedge spi_ss_i) begin
        if (byte_idx >= 1 && cmd == CMD_WRITE_ENABLE) begin
            wel = 1'b1;
        end else if (byte_idx >= 1 && cmd == CMD_CLEAR_FLAG_STATUS) begin
            prog_err  = 1'b0;
            erase_err = 1'b0;
        end else if (byte_idx >= 4 && (cmd == CMD_PAGE_PROG || cmd == CMD_SUBSECTOR_ERASE)) begin
            if (!wel || addr >= PROT_BASE) begin
                if (cmd == CMD_PAGE_PROG) prog_err = 1'b1;
                else erase_err = 1'b1;
            end else if (cmd == CMD_PAGE_PROG) begin
                for (int k = 0; k < pcount; k++) begin
                    mem[addr[12:0] + 13'(k)] = mem[addr[12:0] + 13'(k)] & pbuf[k];
                end
            end else begin
                for (int j = 0; j < 4096; j++) begin
                    mem[{addr[12], 12'(j)}] = 8'hFF;
                end
            end
            wel        = 1'b0;
            rng        = xorshift(rng);
            busy_polls = int'(rng[1:0]);   // 0..3 busy polls
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_flash_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_flash_ctrl;

    import flash_pkg::*;

    localparam int          TIMEOUT   = 5000;
    localparam logic [23:0] PROT_BASE = 24'h001F00;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        start_i;
    logic [1:0]  op_mode_i;
    logic [23:0] addr_i;
    logic [31:0] data_i;
    wire  [31:0] data_o;
    wire         ready_o, idle_o, write_error_o;
    wire         spi_clk_o, spi_ss_o, spi_mosi_o, spi_miso_i;

    logic [7:0]  image [0:8191];
    logic [31:0] rng = 32'd89166;
    logic [31:0] rdata;
    logic        werr;
    logic [23:0] addrs [0:8];

    always #20 clk_i = ~clk_i;

    flash_ctrl_top UUT (
        .clk_i (clk_i), .rst_ni (rst_ni), .start_i (start_i), .op_mode_i (op_mode_i),
        .addr_i (addr_i), .data_i (data_i), .data_o (data_o), .ready_o (ready_o),
        .idle_o (idle_o), .write_error_o (write_error_o), .spi_clk_o (spi_clk_o),
        .spi_ss_o (spi_ss_o), .spi_mosi_o (spi_mosi_o), .spi_miso_i (spi_miso_i)
    );

    flash_model u_flash (
        .spi_clk_i (spi_clk_o), .spi_ss_i (spi_ss_o),
        .spi_mosi_i (spi_mosi_o), .spi_miso_o (spi_miso_i)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] image_word(input logic [23:0] a);
        return {image[a[12:0] + 13'd3], image[a[12:0] + 13'd2],
                image[a[12:0] + 13'd1], image[a[12:0]]};
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else stop_with_error($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                       $time, name, got, exp));
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (idle_o !== 1'b1) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) stop_with_error("timeout waiting for idle_o");
        end
    endtask

    // one start pulse, then wait for ready_o and capture the results there
    task automatic run_op(input logic [1:0] op, input logic [23:0] a, input logic [31:0] d);
        int n;
        wait_idle();
        @(posedge clk_i);
        #2;
        start_i   = 1'b1;
        op_mode_i = op;
        addr_i    = a;
        data_i    = d;
        @(posedge clk_i);
        #2 start_i = 1'b0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) stop_with_error("timeout waiting for ready_o");
        end while (ready_o !== 1'b1);
        rdata = data_o;
        werr  = write_error_o;
    endtask

    task automatic quiet_window(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            assert (ready_o === 1'b0) else stop_with_error("unexpected ready_o pulse");
            assert (spi_ss_o === 1'b1) else stop_with_error("unexpected SPI activity");
        end
    endtask

    task automatic program_word(input logic [23:0] a, input logic [31:0] d, input logic ok);
        run_op(OP_PROGRAM, a, d);
        check_val("write_error_o", {31'd0, werr}, {31'd0, !ok});
        if (ok) begin
            for (int k = 0; k < 4; k++) begin
                image[a[12:0] + 13'(k)] = image[a[12:0] + 13'(k)] & d[8*k +: 8];
            end
        end
    endtask

    task automatic read_check(input logic [23:0] a);
        run_op(OP_READ, a, 32'h0);
        check_val($sformatf("data_o @%h", a), rdata, image_word(a));
    endtask

    initial begin
        logic [31:0] t;
        for (int i = 0; i < 8192; i++) image[i] = 8'hFF;
        rst_ni    = 1'b0;
        start_i   = 1'b0;
        op_mode_i = 2'b00;
        addr_i    = '0;
        data_i    = '0;
        repeat (3) @(posedge clk_i);
        #2 rst_ni = 1'b1;
        @(negedge clk_i);
        check_val("idle_o", {31'd0, idle_o}, 32'd1);
        check_val("ready_o", {31'd0, ready_o}, 32'd0);
        check_val("write_error_o", {31'd0, write_error_o}, 32'd0);
        check_val("spi_clk_o", {31'd0, spi_clk_o}, 32'd0);
        check_val("spi_ss_o", {31'd0, spi_ss_o}, 32'd1);

        read_check(24'h000040);                  // blank flash reads all ones
        check_val("data_o blank", rdata, 32'hFFFF_FFFF);

        addrs[0] = 24'h001000;                   // just outside subsector 0
        for (int i = 1; i < 9; i++) begin
            t = next_rand() % 32'h1F00;
            addrs[i] = {t[23:2], 2'b00};
        end
        for (int i = 0; i < 9; i++) program_word(addrs[i], next_rand(), 1'b1);
        for (int i = 0; i < 9; i++) read_check(addrs[i]);

        run_op(OP_ERASE, 24'h000200, 32'h0);
        check_val("write_error_o", {31'd0, werr}, 32'd0);
        for (int i = 0; i < 4096; i++) image[i] = 8'hFF;
        read_check(24'h000000);
        read_check(24'h000FFC);
        for (int i = 0; i < 9; i++) read_check(addrs[i]);

        program_word(PROT_BASE + 24'h40, 32'h1234_5678, 1'b0);
        read_check(PROT_BASE + 24'h40);
        run_op(OP_ERASE, PROT_BASE + 24'h80, 32'h0);
        check_val("write_error_o", {31'd0, werr}, 32'd1);
        read_check(addrs[0]);                    // subsector 1 left intact
        program_word(24'h000100, next_rand(), 1'b1);   // error flags were cleared
        read_check(24'h000100);

        wait_idle();
        @(posedge clk_i);
        #2;
        start_i   = 1'b1;
        op_mode_i = 2'b11;
        @(posedge clk_i);
        #2 start_i = 1'b0;
        quiet_window(TIMEOUT);

        @(posedge clk_i);
        #2;
        start_i   = 1'b1;
        op_mode_i = OP_READ;
        addr_i    = 24'h001000;
        @(posedge clk_i);
        #2;
        op_mode_i = OP_PROGRAM;                  // second start while busy
        data_i    = 32'h0;
        assert (idle_o === 1'b0) else stop_with_error("idle_o still high after start");
        @(posedge clk_i);
        #2 start_i = 1'b0;
        t = 0;
        while (ready_o !== 1'b1) begin
            @(negedge clk_i);
            t++;
            if (t > TIMEOUT) stop_with_error("timeout waiting for read to finish");
        end
        check_val("data_o busy start", data_o, image_word(24'h001000));
        quiet_window(TIMEOUT);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/flash_ctrl_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module flash_ctrl_top (
    input  wire                          clk_i,
    input  wire                          rst_ni,

    input  wire                          start_i,
    input  wire  [1:0]                   op_mode_i,
    input  wire  [flash_pkg::ADDR_W-1:0] addr_i,
    input  wire  [flash_pkg::DATA_W-1:0] data_i,
    output logic [flash_pkg::DATA_W-1:0] data_o,
    output logic                         ready_o,
    output logic                         idle_o,
    output logic                         write_error_o,

    output logic                         spi_clk_o,
    output logic                         spi_ss_o,
    output logic                         spi_mosi_o,
    input  wire                          spi_miso_i
);

    import flash_pkg::*;

    // sequencer to engine
    logic                  tran_start;
    logic [7:0]            tran_cmd;
    logic [ADDR_W-1:0]     tran_addr;
    logic                  tran_addr_en;
    logic [BYTE_CNT_W-1:0] tran_nbytes;
    logic                  tran_rd;
    logic [DATA_W-1:0]     tran_wdata;
    logic                  tran_done;
    logic [DATA_W-1:0]     tran_rdata;
    logic                  tran_idle;

    // engine to clock generator
    logic                  sclk_en;
    logic                  shift_p;
    logic                  sample_p;

    flash_op_seq u_flash_op_seq (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .start_i        (start_i),
        .op_mode_i      (op_mode_i),
        .addr_i         (addr_i),
        .data_i         (data_i),
        .tran_done_i    (tran_done),
        .tran_rdata_i   (tran_rdata),
        .tran_idle_i    (tran_idle),
        .tran_start_o   (tran_start),
        .tran_cmd_o     (tran_cmd),
        .tran_addr_o    (tran_addr),
        .tran_addr_en_o (tran_addr_en),
        .tran_nbytes_o  (tran_nbytes),
        .tran_rd_o      (tran_rd),
        .tran_wdata_o   (tran_wdata),
        .data_o         (data_o),
        .ready_o        (ready_o),
        .idle_o         (idle_o),
        .write_error_o  (write_error_o)
    );

    spi_tran_engine u_spi_tran_engine (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .tran_start_i   (tran_start),
        .tran_cmd_i     (tran_cmd),
        .tran_addr_i    (tran_addr),
        .tran_addr_en_i (tran_addr_en),
        .tran_nbytes_i  (tran_nbytes),
        .tran_rd_i      (tran_rd),
        .tran_wdata_i   (tran_wdata),
        .shift_p_i      (shift_p),
        .sample_p_i     (sample_p),
        .spi_miso_i     (spi_miso_i),
        .tran_done_o    (tran_done),
        .tran_rdata_o   (tran_rdata),
        .tran_idle_o    (tran_idle),
        .sclk_en_o      (sclk_en),
        .spi_ss_o       (spi_ss_o),
        .spi_mosi_o     (spi_mosi_o)
    );

    spi_clk_gen u_spi_clk_gen (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .sclk_en_i  (sclk_en),
        .spi_clk_o  (spi_clk_o),
        .shift_p_o  (shift_p),
        .sample_p_o (sample_p)
    );

endmodule

`default_nettype wire

// ==== verilog/flash_op_seq.sv ====
`default_nettype none
`timescale 1ns/100ps

module flash_op_seq (
    input  wire                              clk_i,
    input  wire                              rst_ni,

    input  wire                              start_i,
    input  wire  [1:0]                       op_mode_i,
    input  wire  [flash_pkg::ADDR_W-1:0]     addr_i,
    input  wire  [flash_pkg::DATA_W-1:0]     data_i,

    input  wire                              tran_done_i,
    input  wire  [flash_pkg::DATA_W-1:0]     tran_rdata_i,
    input  wire                              tran_idle_i,
    output logic                             tran_start_o,
    output logic [7:0]                       tran_cmd_o,
    output logic [flash_pkg::ADDR_W-1:0]     tran_addr_o,
    output logic                             tran_addr_en_o,
    output logic [flash_pkg::BYTE_CNT_W-1:0] tran_nbytes_o,
    output logic                             tran_rd_o,
    output logic [flash_pkg::DATA_W-1:0]     tran_wdata_o,

    output logic [flash_pkg::DATA_W-1:0]     data_o,
    output logic                             ready_o,
    output logic                             idle_o,
    output logic                             write_error_o
);

    import flash_pkg::*;

    logic [2:0]        state_q;
    logic [1:0]        op_q;       // latched host op
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;
    logic              pend_q;     // transaction of this state not yet issued
    logic              ready_q;
    logic              werr_q;
    logic              fsr_err;
    logic              accept;

    assign idle_o  = (state_q == S_IDLE) && tran_idle_i;
    assign accept  = idle_o && start_i && (op_mode_i inside {OP_READ, OP_PROGRAM, OP_ERASE});
    assign fsr_err = tran_rdata_i[FSR_ERASE_ERR_BIT] | tran_rdata_i[FSR_PROG_ERR_BIT];

    // issue once the engine has finished its ss gap
    assign tran_start_o = pend_q && tran_idle_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= S_IDLE;
            op_q    <= OP_READ;
            pend_q  <= 1'b0;
            ready_q <= 1'b0;
            werr_q  <= 1'b0;
            rdata_q <= '0;
        end else begin
            ready_q <= 1'b0;
            if (tran_start_o) begin
                pend_q <= 1'b0;
            end
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        op_q    <= op_mode_i;
                        pend_q  <= 1'b1;
                        state_q <= (op_mode_i == OP_READ) ? S_READ : S_WREN;
                    end
                end
                S_READ: begin
                    if (tran_done_i) begin
                        rdata_q <= tran_rdata_i;
                        ready_q <= 1'b1;
                        state_q <= S_IDLE;
                    end
                end
                S_WREN: begin
                    if (tran_done_i) begin
                        pend_q  <= 1'b1;
                        state_q <= (op_q == OP_PROGRAM) ? S_PROG : S_ERASE;
                    end
                end
                S_PROG, S_ERASE: begin
                    if (tran_done_i) begin
                        pend_q  <= 1'b1;
                        state_q <= S_POLL;
                    end
                end
                S_POLL: begin
                    if (tran_done_i) begin
                        if (!tran_rdata_i[FSR_READY_BIT]) begin
                            pend_q <= 1'b1;              // still busy, poll again
                        end else if (fsr_err) begin
                            werr_q  <= 1'b1;
                            pend_q  <= 1'b1;
                            state_q <= S_CLR;
                        end else begin
                            werr_q  <= 1'b0;
                            ready_q <= 1'b1;
                            state_q <= S_IDLE;
                        end
                    end
                end
                S_CLR: begin
                    if (tran_done_i) begin
                        ready_q <= 1'b1;                 // error stays reported
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q  <= addr_i;
            wdata_q <= data_i;
        end
    end

    // transaction shape per state
    always_comb begin
        tran_cmd_o     = CMD_READ_FLAG_STATUS;
        tran_addr_en_o = 1'b0;
        tran_nbytes_o  = '0;
        tran_rd_o      = 1'b0;
        case (state_q)
            S_READ: begin
                tran_cmd_o     = CMD_READ;
                tran_addr_en_o = 1'b1;
                tran_nbytes_o  = BYTE_CNT_W'(4);
                tran_rd_o      = 1'b1;
            end
            S_WREN:  tran_cmd_o = CMD_WRITE_ENABLE;
            S_PROG: begin
                tran_cmd_o     = CMD_PAGE_PROG;
                tran_addr_en_o = 1'b1;
                tran_nbytes_o  = BYTE_CNT_W'(4);
            end
            S_ERASE: begin
                tran_cmd_o     = CMD_SUBSECTOR_ERASE;
                tran_addr_en_o = 1'b1;
            end
            S_POLL: begin
                tran_nbytes_o  = BYTE_CNT_W'(1);     // one status byte
                tran_rd_o      = 1'b1;
            end
            S_CLR:   tran_cmd_o = CMD_CLEAR_FLAG_STATUS;
            default: ;
        endcase
    end

    assign tran_addr_o   = addr_q;
    assign tran_wdata_o  = wdata_q;
    assign data_o        = rdata_q;
    assign ready_o       = ready_q;
    assign write_error_o = werr_q;

endmodule

`default_nettype wire

// ==== verilog/flash_pkg.sv ====
`default_nettype none

package flash_pkg;

    // flash command opcodes
    localparam logic [7:0] CMD_READ              = 8'h03;
    localparam logic [7:0] CMD_PAGE_PROG         = 8'h02;
    localparam logic [7:0] CMD_SUBSECTOR_ERASE   = 8'h20;
    localparam logic [7:0] CMD_WRITE_ENABLE      = 8'h06;
    localparam logic [7:0] CMD_READ_FLAG_STATUS  = 8'h70;
    localparam logic [7:0] CMD_CLEAR_FLAG_STATUS = 8'h50;

    // host op codes, 2'b11 is not used
    localparam logic [1:0] OP_READ    = 2'b00;
    localparam logic [1:0] OP_PROGRAM = 2'b01;
    localparam logic [1:0] OP_ERASE   = 2'b10;

    // flag status register bits
    localparam int FSR_READY_BIT     = 7;
    localparam int FSR_ERASE_ERR_BIT = 5;
    localparam int FSR_PROG_ERR_BIT  = 4;

    localparam int ADDR_W     = 24;
    localparam int DATA_W     = 32;
    localparam int BYTE_CNT_W = 3;   // data bytes 0..4

    localparam int SPI_HALF_PERIOD = 2;   // clk_i cycles per sclk half period
    localparam int SS_GAP_CYCLES   = 4;   // min ss high time between transactions
    localparam int HALF_CNT_W      = $clog2(SPI_HALF_PERIOD + 1);
    localparam int SS_TMR_W        = $clog2(SS_GAP_CYCLES + SPI_HALF_PERIOD + 1);

    // operation sequencer states
    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_READ  = 3'd1;
    localparam logic [2:0] S_WREN  = 3'd2;
    localparam logic [2:0] S_PROG  = 3'd3;
    localparam logic [2:0] S_ERASE = 3'd4;
    localparam logic [2:0] S_POLL  = 3'd5;
    localparam logic [2:0] S_CLR   = 3'd6;

    // transfer engine states
    localparam logic [2:0] E_IDLE  = 3'd0;
    localparam logic [2:0] E_SETUP = 3'd1;
    localparam logic [2:0] E_XFER  = 3'd2;
    localparam logic [2:0] E_HOLD  = 3'd3;
    localparam logic [2:0] E_GAP   = 3'd4;

    // byte phases within one transaction
    localparam logic [1:0] PH_CMD  = 2'd0;
    localparam logic [1:0] PH_ADDR = 2'd1;
    localparam logic [1:0] PH_DATA = 2'd2;

endpackage

`default_nettype wire

// ==== verilog/spi_clk_gen.sv ====
`default_nettype none
`timescale 1ns/100ps

module spi_clk_gen (
    input  wire  clk_i,
    input  wire  rst_ni,
    input  wire  sclk_en_i,
    output logic spi_clk_o,
    output logic shift_p_o,
    output logic sample_p_o
);

    import flash_pkg::*;

    logic [HALF_CNT_W-1:0] half_cnt_q;
    logic                  sclk_q;
    logic                  half_end;

    assign half_end = sclk_en_i && (half_cnt_q == HALF_CNT_W'(SPI_HALF_PERIOD - 1));

    // flagged on the cycle whose edge toggles sclk
    assign sample_p_o = half_end && !sclk_q;     // rising edge next
    assign shift_p_o  = half_end && sclk_q;      // falling edge next
    assign spi_clk_o  = sclk_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            half_cnt_q <= '0;
            sclk_q     <= 1'b0;
        end else if (!sclk_en_i) begin
            half_cnt_q <= '0;
            sclk_q     <= 1'b0;                  // mode 0 idles low
        end else if (half_end) begin
            half_cnt_q <= '0;
            sclk_q     <= !sclk_q;
        end else begin
            half_cnt_q <= half_cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/spi_tran_engine.sv ====
`default_nettype none
`timescale 1ns/100ps

module spi_tran_engine (
    input  wire                              clk_i,
    input  wire                              rst_ni,

    input  wire                              tran_start_i,
    input  wire  [7:0]                       tran_cmd_i,
    input  wire  [flash_pkg::ADDR_W-1:0]     tran_addr_i,
    input  wire                              tran_addr_en_i,
    input  wire  [flash_pkg::BYTE_CNT_W-1:0] tran_nbytes_i,
    input  wire                              tran_rd_i,
    input  wire  [flash_pkg::DATA_W-1:0]     tran_wdata_i,
    output logic                             tran_done_o,
    output logic [flash_pkg::DATA_W-1:0]     tran_rdata_o,
    output logic                             tran_idle_o,

    input  wire                              shift_p_i,
    input  wire                              sample_p_i,
    output logic                             sclk_en_o,

    output logic                             spi_ss_o,
    output logic                             spi_mosi_o,
    input  wire                              spi_miso_i
);

    import flash_pkg::*;

    logic [2:0]            state_q;
    logic [1:0]            phase_q;
    logic [2:0]            bit_cnt_q;
    logic [BYTE_CNT_W-1:0] byte_cnt_q;
    logic [7:0]            shreg_q;
    logic [SS_TMR_W-1:0]   tmr_q;
    logic                  done_q;
    logic [ADDR_W-1:0]     addr_q;
    logic                  addr_en_q;
    logic [BYTE_CNT_W-1:0] nbytes_q;
    logic                  rd_q;
    logic [DATA_W-1:0]     wdata_q;
    logic [DATA_W-1:0]     rdata_q;

    logic                  tmr_half;
    logic                  tmr_gap;
    logic                  byte_end;
    logic                  last_byte;
    logic                  load_next;
    logic [1:0]            next_phase;
    logic [BYTE_CNT_W-1:0] next_byte;
    logic [7:0]            next_shreg;

    assign tmr_half  = tmr_q == SS_TMR_W'(SPI_HALF_PERIOD - 1);
    assign tmr_gap   = tmr_q == SS_TMR_W'(SS_GAP_CYCLES - 1);
    assign byte_end  = (state_q == E_XFER) && shift_p_i && (bit_cnt_q == 3'd7);
    assign load_next = byte_end && !last_byte;

    // what follows the byte now on the wire
    always_comb begin
        next_phase = phase_q;
        next_byte  = byte_cnt_q + 1'b1;
        last_byte  = 1'b0;
        case (phase_q)
            PH_CMD: begin
                next_byte = '0;
                if (addr_en_q) begin
                    next_phase = PH_ADDR;
                end else if (nbytes_q != '0) begin
                    next_phase = PH_DATA;
                end else begin
                    last_byte = 1'b1;
                end
            end
            PH_ADDR: begin
                if (byte_cnt_q == BYTE_CNT_W'(2)) begin
                    next_byte = '0;
                    if (nbytes_q != '0) begin
                        next_phase = PH_DATA;
                    end else begin
                        last_byte = 1'b1;
                    end
                end
            end
            default: last_byte = (next_byte == nbytes_q);
        endcase
    end

    // address goes out msb byte first, data lowest byte first
    assign next_shreg = (next_phase == PH_ADDR) ? addr_q[ADDR_W-1 -: 8] : wdata_q[7:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= E_IDLE;
            phase_q    <= PH_CMD;
            bit_cnt_q  <= '0;
            byte_cnt_q <= '0;
            shreg_q    <= '0;
            tmr_q      <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                E_IDLE: begin
                    if (tran_start_i) begin
                        state_q    <= E_SETUP;
                        phase_q    <= PH_CMD;
                        bit_cnt_q  <= '0;
                        byte_cnt_q <= '0;
                        shreg_q    <= tran_cmd_i;    // first bit valid before first rise
                        tmr_q      <= '0;
                    end
                end
                E_SETUP: begin
                    if (tmr_half) begin
                        state_q <= E_XFER;
                    end else begin
                        tmr_q <= tmr_q + 1'b1;
                    end
                end
                E_XFER: begin
                    if (shift_p_i) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q != 3'd7) begin
                            shreg_q <= shreg_q << 1;
                        end else if (last_byte) begin
                            state_q <= E_HOLD;
                            tmr_q   <= '0;
                        end else begin
                            phase_q    <= next_phase;
                            byte_cnt_q <= next_byte;
                            shreg_q    <= next_shreg;
                        end
                    end
                end
                E_HOLD: begin
                    if (tmr_half) begin
                        state_q <= E_GAP;        // ss rises here
                        tmr_q   <= '0;
                        done_q  <= 1'b1;
                    end else begin
                        tmr_q <= tmr_q + 1'b1;
                    end
                end
                E_GAP: begin
                    if (tmr_gap) begin
                        state_q <= E_IDLE;
                    end else begin
                        tmr_q <= tmr_q + 1'b1;
                    end
                end
                default: state_q <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == E_IDLE) && tran_start_i) begin
            addr_q    <= tran_addr_i;
            addr_en_q <= tran_addr_en_i;
            nbytes_q  <= tran_nbytes_i;
            rd_q      <= tran_rd_i;
            wdata_q   <= tran_wdata_i;
            rdata_q   <= '0;
        end else if (load_next) begin
            if (next_phase == PH_ADDR) begin
                addr_q <= addr_q << 8;
            end else begin
                wdata_q <= wdata_q >> 8;
            end
        end
        // byte k, bit b lands at word bit 8k+7-b
        if ((state_q == E_XFER) && sample_p_i && (phase_q == PH_DATA) && rd_q) begin
            rdata_q[{byte_cnt_q[1:0], ~bit_cnt_q}] <= spi_miso_i;
        end
    end

    assign sclk_en_o    = state_q == E_XFER;
    assign spi_ss_o     = !(state_q inside {E_SETUP, E_XFER, E_HOLD});
    assign spi_mosi_o   = shreg_q[7];
    assign tran_idle_o  = state_q == E_IDLE;
    assign tran_done_o  = done_q;
    assign tran_rdata_o = rdata_q;

endmodule

`default_nettype wire
